// File: verification/cpl_tx_stim.txt
# dw_len byte_cnt lower_addr tag req_id tc attr (hex), then grant delay and stall flag (decimal)
# one completion command per line, sent back to back in this order
010 040 00 01 0100 0 0 0 0
005 014 04 02 0100 1 1 2 0
006 018 08 03 0200 2 2 1 0
008 020 10 04 0200 3 3 0 1
00d 034 0c 05 0300 0 0 3 0
010 040 00 06 0300 7 1 0 1
020 080 40 07 1234 0 0 5 1
003 00c 1c 08 1234 4 2 0 0
018 060 20 09 abcd 5 3 2 1
040 100 00 0a abcd 0 0 1 1
002 008 7c 0b 00ff 6 0 0 0
001 004 7f 0c 00ff 0 1 4 0
064 190 00 0d 4321 1 2 0 1
00f 03c 60 0e 4321 2 3 1 0

// File: files.f
+incdir+include
src/cpl_tx_pkg.sv
src/cpl_beat_if.sv
src/cpl_cmd_fetch.sv
src/cpl_sequencer.sv
src/cpl_tlp_aligner.sv
src/cpl_tx_top.sv
verification/tb_clock_gen.sv
verification/cpl_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the completion transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module cpl_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile step returned an error"
  exit 1
fi

./obj_dir/Vcpl_tx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation returned an error"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0

// File: verification/cpl_tx_tb.sv
/*
 * completion transmit controller testbench
 * models the command FIFO, completion buffer, arbiter and tx FIFO count,
 * and checks every tx FIFO word against the command list of the stim file
 */
`timescale 1ns/100ps
`include "cpl_tx_settings.svh"

module cpl_tx_tb;

  localparam int MAX_CMDS = 32;

  logic                       clk;
  logic                       rstn;
  logic [12:0]                bus_dev;
  logic [`CMD_W-1:0]          cmd_data;
  logic [`CMD_CNT_W-1:0]      cmd_count;
  logic                       cmd_rd;
  logic [`CPL_BUF_AW-1:0]     rd_addr;
  logic [`CPL_LINE_DW*32-1:0] buf_data;
  logic [`TX_CNT_W-1:0]       tx_count;
  logic                       tx_wr;
  logic [`TX_WORD_W-1:0]      tx_data;
  logic                       arb_req;
  logic                       arb_gnt;

  cpl_tx_pkg::cpl_cmd_t cmds [MAX_CMDS];
  int                   gnt_delay [MAX_CMDS];
  int                   stall_en [MAX_CMDS];
  cpl_tx_pkg::cpl_cmd_t cmd_q [$];       // command FIFO contents, front is show-ahead
  int                   num_cmds;
  int                   errors;
  int                   checks;
  integer               seed;
  int                   hdr_cnt;         // header words seen, picks the arbiter delay
  int                   done_cnt;        // completions finished with eop
  int                   word_idx;
  int                   start_line;      // first buffer line of the expected completion
  int                   req_cycles;
  int                   stall_left;
  int                   hi_run;          // consecutive edges with the count above threshold
  int                   wait_cnt;
  logic                 grant_seen;
  logic                 in_cpl;

  tb_clock_gen clock_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  cpl_tx_top UUT (
    .Clk_i             (clk),
    .Rstn_i            (rstn),
    .bus_dev_i         (bus_dev),
    .cmd_fifo_data_i   (cmd_data),
    .cmd_fifo_count_i  (cmd_count),
    .cmd_fifo_rd_o     (cmd_rd),
    .cpl_buf_rd_addr_o (rd_addr),
    .cpl_buf_data_i    (buf_data),
    .tx_fifo_count_i   (tx_count),
    .tx_fifo_wr_o      (tx_wr),
    .tx_fifo_data_o    (tx_data),
    .arb_req_o         (arb_req),
    .arb_granted_i     (arb_gnt)
  );

  // completion buffer, DW j of line a holds the line number over the DW number
  for (genvar j = 0; j < `CPL_LINE_DW; j++)
  begin : g_buf
    assign buf_data[j*32 +: 32] = {7'b0, rd_addr, 16'(j)};
  end

  function automatic logic [31:0] line_dw(input int line, input int j);
    return {7'b0, 9'(line), 16'(j)};
  endfunction

  // 3-DW completion-with-data header straight from the PCIe field layout
  function automatic logic [31:0] header_dw(input cpl_tx_pkg::cpl_cmd_t c, input int i);
    if (i == 0)
      return {3'b010, 5'b01010, 1'b0, c.tc, 4'b0, 2'b0, c.attr, 2'b0, c.dw_len};
    else if (i == 1)
      return {bus_dev, 3'b0, 3'b0, 1'b0, c.byte_cnt};  // successful status
    return {c.req_id, c.tag, 1'b0, c.lower_addr};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    int    len, bc, la, tag, rid, tc, attr, dly, stl;
    fd = $fopen("verification/cpl_tx_stim.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file");
      errors++;
      return;
    end
    while (!$feof(fd) && num_cmds < MAX_CMDS)
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.substr(0, 0) != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %d %d",
                    len, bc, la, tag, rid, tc, attr, dly, stl);
        if (n == 9)
        begin
          cmds[num_cmds] = '{pad: 6'd0, attr: 2'(attr), tc: 3'(tc), dw_len: 10'(len),
                             byte_cnt: 12'(bc), lower_addr: 7'(la), tag: 8'(tag),
                             req_id: 16'(rid)};
          gnt_delay[num_cmds] = dly;
          stall_en[num_cmds]  = stl;
          num_cmds++;
        end
      end
    end
    $fclose(fd);
  endtask

  // one block samples the outputs before the edge and then drives the models
  always @(posedge clk)
  begin
    cpl_tx_pkg::tlp_beat_u w;
    cpl_tx_pkg::cpl_cmd_t  c;
    int                    nb;
    int                    cur;
    int                    valid;
    logic                  last;
    logic [31:0]           exp;
    w = tx_data[255:0];
    if (rstn)
    begin
      hi_run = (tx_count > `TX_CNT_W'(`TX_FIFO_ALMOST_FULL)) ? hi_run + 1 : 0;
      if (tx_wr && hi_run >= 3)
      begin
        errors++;
        $display("tx FIFO written while the count stayed above the threshold");
      end
      if (in_cpl && !(tx_wr && tx_data[257]))
        check_val("arb_req_o", 32'(arb_req), 32'd1);  // request holds until eop
      if (tx_wr && done_cnt >= num_cmds)
      begin
        errors++;
        $display("tx FIFO written after the last completion");
      end
      else if (tx_wr)
      begin
        c     = cmds[done_cnt];
        nb    = (int'(c.dw_len) + 3 + 7) / 8;
        last  = (word_idx == nb - 1);
        valid = last ? 8 - ((8 - (int'(c.dw_len) + 3) % 8) % 8) : 8;
        check_val("sop", 32'(tx_data[256]), 32'(word_idx == 0));
        check_val("eop", 32'(tx_data[257]), 32'(last));
        check_val("empty", 32'(tx_data[260:258]), last ? 32'(8 - valid) : 32'd0);
        for (int j = 0; j < valid; j++)
        begin
          if (word_idx == 0)
            exp = (j < 3) ? header_dw(c, j) : line_dw(start_line, j - 3);
          else if (j < 3)
            exp = line_dw(start_line + word_idx - 1, j + 5);  // carried tail of the last line
          else
            exp = line_dw(start_line + word_idx, j - 3);
          check_val($sformatf("tx_fifo_data_o dw%0d", j), w.dw[j], exp);
        end
        if (word_idx == 0)
        begin
          if (!grant_seen)
          begin
            errors++;
            $display("header written before the arbiter granted");
          end
          grant_seen = 1'b0;
          hdr_cnt++;
          req_cycles = 0;
          arb_gnt <= 1'b0;
        end
        if (last)
        begin
          done_cnt++;
          start_line += (int'(c.dw_len) + 7) / 8;  // next command starts on the next line
          word_idx = 0;
          in_cpl   = 1'b0;
        end
        else
        begin
          word_idx++;
          in_cpl = 1'b1;
        end
      end
      // the grant still up on a header write belongs to that header
      if (arb_gnt && !(tx_wr && tx_data[256]))
        grant_seen = 1'b1;
    end
    // show-ahead command FIFO
    if (rstn && cmd_rd && cmd_q.size() > 0)
      void'(cmd_q.pop_front());
    cmd_count <= rstn ? `CMD_CNT_W'(cmd_q.size()) : '0;
    cmd_data  <= (cmd_q.size() > 0) ? `CMD_W'(cmd_q[0]) : '0;
    // arbiter grants the pending request after the delay of its command
    cur = (hdr_cnt < num_cmds) ? hdr_cnt : num_cmds - 1;
    if (cur < 0)
      cur = 0;
    if (!arb_req)
    begin
      req_cycles = 0;
      arb_gnt <= 1'b0;
    end
    else if (!arb_gnt)
    begin
      if (req_cycles >= gnt_delay[cur])
        arb_gnt <= 1'b1;
      req_cycles++;
    end
    // random stretches of a nearly full tx FIFO for commands that ask for stalls
    if (stall_left > 0)
    begin
      stall_left--;
      tx_count <= `TX_CNT_W'(12);
    end
    else if (stall_en[cur] != 0 && ($unsigned($random(seed)) % 4) == 0)
    begin
      stall_left = $unsigned($random(seed)) % 6;
      tx_count <= `TX_CNT_W'(12);
    end
    else
      tx_count <= `TX_CNT_W'($unsigned($random(seed)) % 8);
  end

  initial
  begin
    seed       = 32'h18ac_af58;
    errors     = 0;
    checks     = 0;
    num_cmds   = 0;
    hdr_cnt    = 0;
    done_cnt   = 0;
    word_idx   = 0;
    start_line = 0;
    req_cycles = 0;
    stall_left = 0;
    hi_run     = 0;
    grant_seen = 1'b0;
    in_cpl     = 1'b0;
    bus_dev    = 13'h0a5b;
    cmd_data   = '0;
    cmd_count  = '0;
    tx_count   = '0;
    arb_gnt    = 1'b0;
    load_stim();
    for (int i = 0; i < num_cmds; i++)
      cmd_q.push_back(cmds[i]);
    wait_cnt = 0;
    while (rstn !== 1'b1 && wait_cnt < 100)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (rstn !== 1'b1)
    begin
      errors++;
      $display("reset was never released");
    end
    // outputs still show their reset values on the first edge after release
    check_val("cmd_fifo_rd_o", 32'(cmd_rd), 32'd0);
    check_val("arb_req_o", 32'(arb_req), 32'd0);
    check_val("tx_fifo_wr_o", 32'(tx_wr), 32'd0);
    check_val("cpl_buf_rd_addr_o", 32'(rd_addr), 32'd0);
    wait_cnt = 0;
    while (done_cnt < num_cmds && wait_cnt < 20000)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (done_cnt < num_cmds)
    begin
      errors++;
      $display("timed out with %0d of %0d completions sent", done_cnt, num_cmds);
    end
    repeat (5) @(posedge clk);  // let a stray write show up
    $display("errors: %0d in %0d checks, %0d completions", errors, checks, done_cnt);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 10 ns clock, active-low reset held for the first 8 rising edges
 */
`timescale 1ns/100ps

module tb_clock_gen
(
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial
  begin
    repeat (8) @(posedge clk_o);
    rstn_o <= 1'b1;  // released on an edge like every other input
  end

endmodule

// File: src/cpl_tx_top.sv
/*
 * completion transmit controller top
 * command fetch, beat sequencer and TLP aligner for a 256-bit tx path
 */
`timescale 1ns/100ps
`include "cpl_tx_settings.svh"

module cpl_tx_top
(
  input  logic                        Clk_i,
  input  logic                        Rstn_i,
  input  logic [12:0]                 bus_dev_i,          // bus and device of this function
  input  logic [`CMD_W-1:0]           cmd_fifo_data_i,
  input  logic [`CMD_CNT_W-1:0]       cmd_fifo_count_i,
  output logic                        cmd_fifo_rd_o,
  output logic [`CPL_BUF_AW-1:0]      cpl_buf_rd_addr_o,
  input  logic [`CPL_LINE_DW*32-1:0]  cpl_buf_data_i,     // line at the read address, same cycle
  input  logic [`TX_CNT_W-1:0]        tx_fifo_count_i,
  output logic                        tx_fifo_wr_o,
  output logic [`TX_WORD_W-1:0]       tx_fifo_data_o,
  output logic                        arb_req_o,
  input  logic                        arb_granted_i
);

  logic                 cmd_valid;
  logic                 cmd_take;
  cpl_tx_pkg::cpl_cmd_t cmd;

  cpl_beat_if beat_bus ();

  cpl_cmd_fetch u_fetch (
    .Clk_i            (Clk_i),
    .Rstn_i           (Rstn_i),
    .cmd_fifo_data_i  (cmd_fifo_data_i),
    .cmd_fifo_count_i (cmd_fifo_count_i),
    .cmd_fifo_rd_o    (cmd_fifo_rd_o),
    .cmd_take_i       (cmd_take),
    .cmd_valid_o      (cmd_valid),
    .cmd_o            (cmd)
  );

  cpl_sequencer u_seq (
    .Clk_i             (Clk_i),
    .Rstn_i            (Rstn_i),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .cmd_take_o        (cmd_take),
    .arb_req_o         (arb_req_o),
    .arb_granted_i     (arb_granted_i),
    .tx_fifo_count_i   (tx_fifo_count_i),
    .cpl_buf_rd_addr_o (cpl_buf_rd_addr_o),
    .beat              (beat_bus.seq)
  );

  cpl_tlp_aligner u_align (
    .Clk_i          (Clk_i),
    .Rstn_i         (Rstn_i),
    .bus_dev_i      (bus_dev_i),
    .cpl_buf_data_i (cpl_buf_data_i),
    .beat           (beat_bus.align),
    .tx_fifo_wr_o   (tx_fifo_wr_o),
    .tx_fifo_data_o (tx_fifo_data_o)
  );

endmodule

// File: src/cpl_tlp_aligner.sv
/*
 * completion TLP aligner
 * builds the 3-DW header and shifts buffer data three DWs up behind it
 * through a holding register, then writes registered words to the tx FIFO
 */
`timescale 1ns/100ps
`include "cpl_tx_settings.svh"

module cpl_tlp_aligner
(
  input  logic                        Clk_i,
  input  logic                        Rstn_i,
  input  logic [12:0]                 bus_dev_i,
  input  logic [`CPL_LINE_DW*32-1:0]  cpl_buf_data_i,
  cpl_beat_if.align                   beat,
  output logic                        tx_fifo_wr_o,
  output logic [`TX_WORD_W-1:0]       tx_fifo_data_o
);

  cpl_tx_pkg::tlp_beat_u        line_u;   // buffer line at the current read address
  cpl_tx_pkg::tlp_beat_u        hold_q;   // last consumed line, its DW5 to DW7 carry over
  cpl_tx_pkg::tlp_beat_u        tlp_u;    // beat as it goes into the output register
  logic [15:0]                  cplter_id;
  logic [`CPL_HDR_DW-1:0][31:0] hdr_dw;

  assign line_u    = cpl_buf_data_i;
  assign cplter_id = {bus_dev_i, 3'b000};  // function number is always zero

  // completion with data: fmt 010, type 01010
  assign hdr_dw[0] = {3'b010, 5'b01010, 1'b0, beat.cmd.tc, 4'b0000,
                      2'b00, beat.cmd.attr, 2'b00, beat.cmd.dw_len};  // no TD, EP or AT
  // successful status, BCM clear
  assign hdr_dw[1] = {cplter_id, 3'b000, 1'b0, beat.cmd.byte_cnt};
  assign hdr_dw[2] = {beat.cmd.req_id, beat.cmd.tag, 1'b0, beat.cmd.lower_addr};

  always_comb
  begin
    tlp_u.part.upper = line_u.dw[4:0];  // the fresh line always fills the upper five DWs
    if (beat.sop)
      tlp_u.part.lower = hdr_dw;
    else
      tlp_u.part.lower = hold_q.dw[7:5];  // leftovers of the previous line
  end

  // the line is kept as soon as a beat has used its lower DWs
  always_ff @(posedge Clk_i)
  begin
    if (beat.line_consume)
      hold_q <= line_u;
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tx_fifo_wr_o <= 1'b0;
    else
      tx_fifo_wr_o <= beat.beat_valid;  // write lands exactly one cycle after its beat
  end

  always_ff @(posedge Clk_i)
  begin
    if (beat.beat_valid)
      tx_fifo_data_o <= {beat.empty_dw, beat.eop, beat.sop, tlp_u};
  end

  // framing from the sequencer never shows up outside a beat
  a_frame_in_beat : assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    (beat.sop || beat.eop) |-> beat.beat_valid);

endmodule

// File: src/cpl_sequencer.sv
/*
 * completion beat sequencer
 * arbitrates for the tx path, then issues the header beat and the data beats
 * while stepping the completion buffer read address one line per consumed beat
 */
`timescale 1ns/100ps
`include "cpl_tx_settings.svh"

module cpl_sequencer
(
  input  logic                   Clk_i,
  input  logic                   Rstn_i,
  input  logic                   cmd_valid_i,
  input  cpl_tx_pkg::cpl_cmd_t   cmd_i,
  output logic                   cmd_take_o,
  output logic                   arb_req_o,
  input  logic                   arb_granted_i,
  input  logic [`TX_CNT_W-1:0]   tx_fifo_count_i,
  output logic [`CPL_BUF_AW-1:0] cpl_buf_rd_addr_o,
  cpl_beat_if.seq                beat
);

  typedef enum logic [1:0] {IDLE, ARB_REQ, ARB_WAIT, SEND} seq_state_e;

  seq_state_e             state_q;
  seq_state_e             state_d;
  logic                   tx_ok_q;       // registered almost-full compare
  logic [7:0]             beat_idx_q;    // beat number inside the current completion
  logic [7:0]             num_beats_q;
  logic [7:0]             num_lines_q;
  logic [2:0]             last_empty_q;
  logic [`CPL_BUF_AW-1:0] rd_addr_q;
  logic [10:0]            len_ext;
  logic [7:0]             beats_calc;
  logic [7:0]             lines_calc;
  logic [2:0]             empty_calc;
  logic [7:0]             num_beats;
  logic [7:0]             num_lines;
  logic [2:0]             last_empty;
  logic                   first_slot;
  logic                   issue;
  logic                   last_beat;

  // beats hold the header in front, lines are counted from the payload only
  assign len_ext    = {1'b0, cmd_i.dw_len};
  assign beats_calc = 8'((len_ext + 11'(`CPL_HDR_DW + `CPL_LINE_DW - 1)) / 11'(`CPL_LINE_DW));
  assign lines_calc = 8'((len_ext + 11'(`CPL_LINE_DW - 1)) / 11'(`CPL_LINE_DW));
  assign empty_calc = 3'((11'(`CPL_LINE_DW) - (len_ext + 11'(`CPL_HDR_DW)) % 11'(`CPL_LINE_DW))
                         % 11'(`CPL_LINE_DW));

  // the header slot works from the live command, later beats from the stored counts
  assign first_slot = (state_q == SEND) && (beat_idx_q == 8'd0);
  assign num_beats  = first_slot ? beats_calc : num_beats_q;
  assign num_lines  = first_slot ? lines_calc : num_lines_q;
  assign last_empty = first_slot ? empty_calc : last_empty_q;

  assign issue     = (state_q == SEND) && tx_ok_q;  // a stalled cycle simply sends nothing
  assign last_beat = issue && (beat_idx_q == 8'(num_beats - 8'd1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (cmd_valid_i)
          state_d = ARB_REQ;
      ARB_REQ, ARB_WAIT:
        if (arb_granted_i && tx_ok_q)
          state_d = SEND;
        else
          state_d = ARB_WAIT;
      SEND:
        // a one-beat completion still shows its own command as valid here
        if (last_beat)
          state_d = (cmd_valid_i && !cmd_take_o) ? ARB_REQ : IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q    <= IDLE;
      tx_ok_q    <= 1'b0;
      beat_idx_q <= 8'd0;
      rd_addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      tx_ok_q <= (tx_fifo_count_i <= `TX_CNT_W'(`TX_FIFO_ALMOST_FULL));
      if (issue)
        beat_idx_q <= last_beat ? 8'd0 : beat_idx_q + 8'd1;
      if (beat.line_consume)
        rd_addr_q <= rd_addr_q + 1'b1;  // never rewinds, so commands take consecutive lines
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (cmd_take_o)
    begin
      num_beats_q  <= beats_calc;
      num_lines_q  <= lines_calc;
      last_empty_q <= empty_calc;
    end
  end

  assign cmd_take_o        = issue && first_slot;  // the command leaves the fetch slot
  assign arb_req_o         = (state_q != IDLE);
  assign cpl_buf_rd_addr_o = rd_addr_q;

  assign beat.beat_valid   = issue;
  assign beat.sop          = issue && first_slot;
  assign beat.eop          = last_beat;
  assign beat.empty_dw     = last_beat ? last_empty : 3'd0;
  assign beat.line_consume = issue && (beat_idx_q < num_lines);
  assign beat.cmd          = cmd_i;

  // a beat needs room that was seen in the tx FIFO count one cycle earlier
  a_no_beat_when_full : assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    beat.beat_valid |-> ($past(tx_fifo_count_i) <= `TX_CNT_W'(`TX_FIFO_ALMOST_FULL)));

  // the buffer is read strictly line after line
  a_addr_step : assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    `CPL_BUF_AW'(cpl_buf_rd_addr_o - $past(cpl_buf_rd_addr_o)) <= `CPL_BUF_AW'(1));

endmodule

// File: src/cpl_cmd_fetch.sv
/*
 * completion command fetch stage
 * pops the show-ahead command FIFO and holds one command for the sequencer
 */
`timescale 1ns/100ps
`include "cpl_tx_settings.svh"

module cpl_cmd_fetch
(
  input  logic                  Clk_i,
  input  logic                  Rstn_i,
  input  logic [`CMD_W-1:0]     cmd_fifo_data_i,
  input  logic [`CMD_CNT_W-1:0] cmd_fifo_count_i,
  output logic                  cmd_fifo_rd_o,
  input  logic                  cmd_take_i,
  output logic                  cmd_valid_o,
  output cpl_tx_pkg::cpl_cmd_t  cmd_o
);

  logic                 slot_valid_q;  // the holding slot has a command
  cpl_tx_pkg::cpl_cmd_t slot_cmd_q;

  // pop whenever the slot is free or is handed over in this very cycle
  assign cmd_fifo_rd_o = (cmd_fifo_count_i != '0) && (!slot_valid_q || cmd_take_i);

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      slot_valid_q <= 1'b0;
    end
    else if (cmd_fifo_rd_o)
    begin
      slot_valid_q <= 1'b1;  // a refill on take keeps the slot full
    end
    else if (cmd_take_i)
    begin
      slot_valid_q <= 1'b0;
    end
  end

  // show-ahead FIFO, so the word is already valid in the pop cycle
  always_ff @(posedge Clk_i)
  begin
    if (cmd_fifo_rd_o)
      slot_cmd_q <= cpl_tx_pkg::cpl_cmd_t'(cmd_fifo_data_i);
  end

  assign cmd_valid_o = slot_valid_q;
  assign cmd_o       = slot_cmd_q;

  // the sequencer only takes what the fetch stage is really holding
  a_take_needs_valid : assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    cmd_take_i |-> cmd_valid_o);

endmodule

// File: src/cpl_beat_if.sv
/*
 * beat bus between the completion sequencer and the TLP aligner
 * one strobe per beat with framing, the empty count and the buffer line usage
 */
`timescale 1ns/100ps

interface cpl_beat_if;

  logic                 beat_valid;    // single-cycle strobe, one per output beat
  logic                 sop;           // header beat of a completion
  logic                 eop;           // last beat of a completion
  logic [2:0]           empty_dw;      // unused upper DWs on the eop beat, zero otherwise
  logic                 line_consume;  // this beat takes the current buffer line

  // command of the completion being started, only looked at with sop
  cpl_tx_pkg::cpl_cmd_t cmd;

  // the sequencer owns every signal of the bus
  modport seq (
    output beat_valid,
    output sop,
    output eop,
    output empty_dw,
    output line_consume,
    output cmd
  );

  // the aligner turns each strobe into one registered tx FIFO word
  modport align (
    input beat_valid,
    input sop,
    input eop,
    input empty_dw,
    input line_consume,
    input cmd
  );

endinterface

// File: src/cpl_tx_pkg.sv
/*
 * completion transmit types
 * decoded completion command and the two views of one 256-bit TLP beat
 */
`include "cpl_tx_settings.svh"

package cpl_tx_pkg;

  // one command word as popped from the command FIFO, msb first
  typedef struct packed {
    logic [5:0]  pad;         // unused top bits
    logic [1:0]  attr;
    logic [2:0]  tc;
    logic [9:0]  dw_len;      // payload length in DWs
    logic [11:0] byte_cnt;    // remaining byte count for the header
    logic [6:0]  lower_addr;  // only goes into the header, payload is line aligned
    logic [7:0]  tag;
    logic [15:0] req_id;
  } cpl_cmd_t;

  // a beat is either eight plain DWs or the header/carry DWs under five payload DWs
  typedef union packed {
    logic [`CPL_LINE_DW-1:0][31:0] dw;  // dw[0] sits in the lowest bits
    struct packed {
      logic [`CPL_LINE_DW-`CPL_HDR_DW-1:0][31:0] upper;  // fresh line DW0 to DW4
      logic [`CPL_HDR_DW-1:0][31:0]              lower;  // header or held DW5 to DW7
    } part;
  } tlp_beat_u;

endpackage

// File: include/cpl_tx_settings.svh
/*
 * completion transmit controller constants
 * widths of the command, buffer and transmit paths and the tx FIFO threshold
 */
`ifndef CPL_TX_SETTINGS_SVH
`define CPL_TX_SETTINGS_SVH

`define CPL_LINE_DW          8    // DWs per buffer line, same as DWs per output beat
`define CPL_HDR_DW           3    // 3-DW completion header
`define CPL_BUF_AW           9    // completion buffer line address

`define CMD_W                64   // raw command word from the command FIFO
`define CMD_CNT_W            5

// transmit FIFO count and the last count at which a beat may still go out
`define TX_CNT_W             4
`define TX_FIFO_ALMOST_FULL  10

// 256 data bits plus sop, eop and a 3-bit empty DW count
`define TX_WORD_W            261

`endif
